// File: all.f
design/xosera_bus_pkg.sv
design/xosera_video_pkg.sv
design/xosera_bus_decode.sv
design/xosera_reg_exec.sv
design/xosera_vram.sv
design/xosera_video_result.sv
design/xosera_core.sv
verif/xosera_core_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= xosera_core_tb
RTL_TOP    ?= xosera_core
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/xosera_core_tb.sv
`default_nettype none
`timescale 1ns/1ps

module xosera_core_tb;
    import xosera_bus_pkg::*;
    import xosera_video_pkg::*;

    localparam int VRAM_AW  = 8;
    localparam int H_VIS    = 32;
    localparam int H_FP     = 4;
    localparam int H_SYNC   = 4;
    localparam int H_BP     = 8;
    localparam int V_VIS    = 8;
    localparam int V_FP     = 1;
    localparam int V_SYNC   = 1;
    localparam int V_BP     = 2;
    localparam int H_TOT    = H_VIS + H_FP + H_SYNC + H_BP;
    localparam int V_TOT    = V_VIS + V_FP + V_SYNC + V_BP;
    localparam int FRAME    = H_TOT * V_TOT;            // cycles per frame
    localparam int N_OPS    = 60;                       // random bus operations
    localparam int N_ACCESS = 2 * (2 * 2**VRAM_AW + 4) + 4 * N_OPS + 120; // upper bound
    localparam int WATCHDOG = N_ACCESS * 7 + 10 * FRAME + 1000;  // 7 cycles per access

    logic       pclk;
    logic       rst_n;
    logic       bus_sel_n;
    logic       bus_rd_nwr;
    logic       bus_bytesel;
    logic [3:0] bus_reg_num;
    logic [7:0] bus_data_in;
    logic [7:0] bus_data_out;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic       hsync;
    logic       vsync;
    logic       de;

    logic [15:0]        m_mem [2**VRAM_AW];     // model of video memory
    logic [VRAM_AW-1:0] m_addr;
    logic [15:0]        m_incr;
    logic [15:0]        m_mode;
    logic [15:0]        m_start;
    logic [15:0]        m_fg;
    logic [15:0]        m_bg;
    logic [7:0]         m_latch;                // even byte held for the odd write
    logic [31:0]        lcg_state;

    xosera_core #(
        .VRAM_AW(VRAM_AW),
        .H_VIS(H_VIS), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_VIS(V_VIS), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_xosera_core (
        .pclk(pclk), .rst_n_i(rst_n),
        .bus_sel_n_i(bus_sel_n), .bus_rd_nwr_i(bus_rd_nwr), .bus_bytesel_i(bus_bytesel),
        .bus_reg_num_i(bus_reg_num), .bus_data_i(bus_data_in), .bus_data_o(bus_data_out),
        .red_o(red), .green_o(green), .blue_o(blue),
        .hsync_o(hsync), .vsync_o(vsync), .de_o(de)
    );

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;                // 100 MHz
    end

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];                // upper bits are the better ones
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // register value as the host should read it back
    function automatic logic [15:0] model_word(input logic [3:0] num);
        case (num)
            VRAM_ADDR:  return 16'(m_addr);
            VRAM_DATA:  return m_mem[m_addr];
            ADDR_INCR:  return m_incr;
            DISP_MODE:  return m_mode;
            DISP_START: return m_start;
            FG_COLOR:   return m_fg;
            BG_COLOR:   return m_bg;
            default:    return 16'h0000;
        endcase
    endfunction

    task automatic model_update(input logic bsel, input logic [3:0] num, input logic [7:0] data);
        logic [15:0] word;
        word = {m_latch, data};
        if (!bsel) begin
            m_latch = data;                     // even byte only latches
        end else begin
            case (num)
                VRAM_ADDR:  m_addr = word[VRAM_AW-1:0];
                VRAM_DATA: begin
                    m_mem[m_addr] = word;
                    m_addr = m_addr + m_incr[VRAM_AW-1:0];  // wraps at top
                end
                ADDR_INCR:  m_incr  = word;
                DISP_MODE:  m_mode  = word;
                DISP_START: m_start = word;
                FG_COLOR:   m_fg    = word;
                BG_COLOR:   m_bg    = word;
                default:    ;
            endcase
        end
    endtask

    // one byte access, 5 cycles select low then 2 high, called on a rising edge
    task automatic bus_write(input logic [3:0] num, input logic bsel, input logic [7:0] data);
        bus_sel_n   <= 1'b0;
        bus_rd_nwr  <= 1'b0;
        bus_bytesel <= bsel;
        bus_reg_num <= num;
        bus_data_in <= data;
        repeat (5) @(posedge pclk);
        bus_sel_n <= 1'b1;
        repeat (2) @(posedge pclk);
        model_update(bsel, num, data);
    endtask

    task automatic bus_read(input logic [3:0] num, input logic bsel, output logic [7:0] d);
        bus_sel_n   <= 1'b0;
        bus_rd_nwr  <= 1'b1;
        bus_bytesel <= bsel;
        bus_reg_num <= num;
        repeat (4) @(posedge pclk);             // byte valid from here
        @(negedge pclk);
        d = bus_data_out;
        @(posedge pclk);
        bus_sel_n <= 1'b1;
        repeat (2) @(posedge pclk);
    endtask

    task automatic write_reg(input logic [3:0] num, input logic [15:0] word);
        bus_write(num, 1'b0, word[15:8]);
        bus_write(num, 1'b1, word[7:0]);
    endtask

    task automatic read_check(input logic [3:0] num);
        logic [7:0]  hi;
        logic [7:0]  lo;
        logic [15:0] exp;
        exp = model_word(num);
        bus_read(num, 1'b0, hi);
        bus_read(num, 1'b1, lo);
        check("bus_data_o even byte", hi, exp[15:8]);
        check("bus_data_o odd byte", lo, exp[7:0]);
    endtask

    task automatic fill_memory();
        write_reg(ADDR_INCR, 16'h0001);
        write_reg(VRAM_ADDR, 16'h0000);
        for (int i = 0; i < 2**VRAM_AW; i++) begin
            write_reg(VRAM_DATA, next_random());
        end
    endtask

    // returns on the falling edge where the first visible pixel shows
    task automatic wait_frame_start();
        do @(negedge pclk); while (vsync);
        do @(negedge pclk); while (!vsync);
        do @(negedge pclk); while (!de);
    endtask

    // walks one frame, checks sync widths, de runs and every pixel
    task automatic check_frame();
        int                 n;
        int                 de_run;
        int                 hs_run;
        int                 vs_run;
        int                 de_lines;
        int                 hs_lines;
        int                 vs_runs;
        logic               de_p;
        logic               hs_p;
        logic               vs_p;
        logic [VRAM_AW-1:0] a;
        vram_word_u         w;
        logic [3:0]         p;
        logic [11:0]        exp;
        n = 0;
        de_run = 0;
        hs_run = 0;
        vs_run = 0;
        de_lines = 0;
        hs_lines = 0;
        vs_runs = 0;
        de_p = 1'b0;
        hs_p = 1'b1;
        vs_p = 1'b1;
        wait_frame_start();
        repeat (FRAME) begin
            if (de) begin
                if (m_mode[0]) begin
                    a = m_start[VRAM_AW-1:0] + VRAM_AW'(n / 16);
                    w = m_mem[a];
                    exp = w.pix1[15 - n % 16] ? m_fg[11:0] : m_bg[11:0];
                end else begin
                    a = m_start[VRAM_AW-1:0] + VRAM_AW'(n / 4);
                    w = m_mem[a];
                    p = w.pix4[3 - n % 4];      // leftmost in top nibble
                    exp = {p, p, p};
                end
                n++;
                de_run++;
            end else begin
                exp = 12'h000;                  // blanked
                if (de_p) begin
                    check("de_o high run", de_run, H_VIS);
                    de_lines++;
                    de_run = 0;
                end
            end
            check("red_o/green_o/blue_o", {red, green, blue}, exp);
            if (!hsync) begin
                hs_run++;
            end else if (!hs_p) begin
                check("hsync_o low run", hs_run, H_SYNC);
                hs_lines++;
                hs_run = 0;
            end
            if (!vsync) begin
                vs_run++;
            end else if (!vs_p) begin
                check("vsync_o low run", vs_run, V_SYNC * H_TOT);
                vs_runs++;
                vs_run = 0;
            end
            de_p = de;
            hs_p = hsync;
            vs_p = vsync;
            @(negedge pclk);
        end
        check("de_o line count", de_lines, V_VIS);
        check("hsync_o pulse count", hs_lines, V_TOT);
        check("vsync_o pulse count", vs_runs, 1);
        @(posedge pclk);                        // back on a rising edge
    endtask

    initial begin
        repeat (WATCHDOG) @(posedge pclk);
        $display("Timeout: the test did not finish within %0d cycles", WATCHDOG);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [15:0] v;
        bus_sel_n   = 1'b1;
        bus_rd_nwr  = 1'b1;
        bus_bytesel = 1'b0;
        bus_reg_num = 4'h0;
        bus_data_in = 8'h00;
        rst_n       = 1'b0;
        lcg_state   = 32'd35;
        m_addr  = '0;
        m_incr  = 16'h0001;
        m_mode  = 16'h0000;
        m_start = 16'h0000;
        m_fg    = 16'h0000;
        m_bg    = 16'h0000;
        m_latch = 8'h00;
        repeat (4) @(posedge pclk);
        rst_n <= 1'b1;
        @(negedge pclk);
        check("hsync_o", hsync, 1'b1);          // idle outputs straight out of reset
        check("vsync_o", vsync, 1'b1);
        check("de_o", de, 1'b0);
        check("red_o/green_o/blue_o", {red, green, blue}, 12'h000);
        @(posedge pclk);
        for (int r = 0; r < 16; r++) begin
            if (r != VRAM_DATA) begin           // memory content is unknown here
                read_check(4'(r));
            end
        end

        fill_memory();
        for (int i = 0; i < N_OPS; i++) begin
            case (next_random() % 4)
                0: write_reg(ADDR_INCR, next_random());
                1: begin
                    write_reg(VRAM_ADDR, next_random());
                    read_check(VRAM_ADDR);
                end
                2: begin
                    write_reg(VRAM_DATA, next_random());
                    read_check(VRAM_ADDR);      // shows the increment
                end
                default: begin
                    write_reg(VRAM_ADDR, next_random());
                    read_check(VRAM_DATA);
                end
            endcase
        end
        write_reg(ADDR_INCR, 16'h0003);         // step across the top of memory
        write_reg(VRAM_ADDR, 16'(2**VRAM_AW - 2));
        write_reg(VRAM_DATA, next_random());
        write_reg(VRAM_DATA, next_random());
        read_check(VRAM_ADDR);
        read_check(VRAM_DATA);

        for (int r = DISP_MODE; r <= BG_COLOR; r++) begin
            v = next_random();
            write_reg(4'(r), v);
            read_check(4'(r));
            bus_write(4'(r), 1'b0, ~v[15:8]);   // half a word, no change yet
            read_check(4'(r));
            bus_write(4'(r), 1'b1, v[7:0]);
            read_check(4'(r));
        end
        for (int r = BG_COLOR + 1; r < 16; r++) begin
            read_check(4'(r));                  // unused numbers still zero with config set
        end

        check_frame();                          // timing under the current config

        fill_memory();
        write_reg(DISP_MODE, 16'h0000);         // 4 bpp grey
        write_reg(DISP_START, next_random());
        check_frame();

        write_reg(DISP_MODE, 16'h0001);         // 1 bpp mono
        write_reg(FG_COLOR, next_random());
        write_reg(BG_COLOR, next_random());
        write_reg(DISP_START, next_random());
        check_frame();

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/xosera_core.sv
`default_nettype none
`timescale 1ns/1ps

module xosera_core #(
    parameter int VRAM_AW = 8,          // video memory address bits
    parameter int H_VIS   = 32,
    parameter int H_FP    = 4,
    parameter int H_SYNC  = 4,
    parameter int H_BP    = 8,
    parameter int V_VIS   = 8,
    parameter int V_FP    = 1,
    parameter int V_SYNC  = 1,
    parameter int V_BP    = 2
) (
    input  logic       pclk,
    input  logic       rst_n_i,
    input  logic       bus_sel_n_i,     // host select, active low
    input  logic       bus_rd_nwr_i,    // 1 read, 0 write
    input  logic       bus_bytesel_i,   // 0 even byte, 1 odd byte
    input  logic [3:0] bus_reg_num_i,
    input  logic [7:0] bus_data_i,
    output logic [7:0] bus_data_o,      // read byte, pad drive is outside
    output logic [3:0] red_o,
    output logic [3:0] green_o,
    output logic [3:0] blue_o,
    output logic       hsync_o,
    output logic       vsync_o,
    output logic       de_o
);
    import xosera_bus_pkg::*;
    import xosera_video_pkg::*;

    bus_access_t        access;         // decode to execute
    disp_cfg_t          cfg;            // execute to video
    logic [VRAM_AW-1:0] vram_addr;      // bus port
    logic               vram_we;
    logic [15:0]        vram_wdata;
    logic [15:0]        vram_rdata;
    logic [VRAM_AW-1:0] fetch_addr;     // raster port
    logic [15:0]        fetch_data;

    xosera_bus_decode u_bus_decode (
        .pclk(pclk), .rst_n_i(rst_n_i),
        .bus_sel_n_i(bus_sel_n_i), .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_bytesel_i(bus_bytesel_i), .bus_reg_num_i(bus_reg_num_i),
        .bus_data_i(bus_data_i), .access_o(access)
    );

    xosera_reg_exec #(.VRAM_AW(VRAM_AW)) u_reg_exec (
        .pclk(pclk), .rst_n_i(rst_n_i), .access_i(access),
        .vram_addr_o(vram_addr), .vram_we_o(vram_we), .vram_wdata_o(vram_wdata),
        .vram_rdata_i(vram_rdata), .cfg_o(cfg), .bus_data_o(bus_data_o)
    );

    xosera_vram #(.VRAM_AW(VRAM_AW)) u_vram (
        .pclk(pclk), .a_addr_i(vram_addr), .a_we_i(vram_we), .a_wdata_i(vram_wdata),
        .a_rdata_o(vram_rdata), .b_addr_i(fetch_addr), .b_rdata_o(fetch_data)
    );

    xosera_video_result #(
        .VRAM_AW(VRAM_AW),
        .H_VIS(H_VIS), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_VIS(V_VIS), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_video_result (
        .pclk(pclk), .rst_n_i(rst_n_i), .cfg_i(cfg),
        .fetch_addr_o(fetch_addr), .fetch_data_i(fetch_data),
        .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
        .hsync_o(hsync_o), .vsync_o(vsync_o), .de_o(de_o)
    );

endmodule

`default_nettype wire

// File: design/xosera_video_result.sv
`default_nettype none
`timescale 1ns/1ps

module xosera_video_result #(
    parameter int VRAM_AW = 8,          // video memory address bits
    parameter int H_VIS   = 32,         // visible pixels per line
    parameter int H_FP    = 4,          // front porch
    parameter int H_SYNC  = 4,          // hsync width
    parameter int H_BP    = 8,          // back porch
    parameter int V_VIS   = 8,          // visible lines
    parameter int V_FP    = 1,
    parameter int V_SYNC  = 1,
    parameter int V_BP    = 2
) (
    input  logic                        pclk,
    input  logic                        rst_n_i,
    input  xosera_video_pkg::disp_cfg_t cfg_i,          // mode, start and colours
    output logic [VRAM_AW-1:0]          fetch_addr_o,   // raster port address
    input  logic [15:0]                 fetch_data_i,   // word, 1 cycle later
    output logic [3:0]                  red_o,
    output logic [3:0]                  green_o,
    output logic [3:0]                  blue_o,
    output logic                        hsync_o,        // active low
    output logic                        vsync_o,        // active low
    output logic                        de_o            // visible pixel
);
    import xosera_video_pkg::*;

    localparam int H_TOT = H_VIS + H_FP + H_SYNC + H_BP;
    localparam int V_TOT = V_VIS + V_FP + V_SYNC + V_BP;
    localparam int HW    = $clog2(H_TOT);
    localparam int VW    = $clog2(V_TOT);

    logic [HW-1:0]      h_cnt;          // pixel within line
    logic [VW-1:0]      v_cnt;          // line within frame
    logic               h_last;
    logic               v_last;
    logic               vis0;           // stage 0 visible
    logic               hs0;
    logic               vs0;
    logic [3:0]         sub_cnt;        // pixel within current word
    logic               sub_last;       // last pixel of word, advance fetch
    logic [VRAM_AW-1:0] fetch_addr;     // word for stage 0 pixel
    logic               vis1;           // stage 1, word arriving now
    logic               hs1;
    logic               vs1;
    logic               mode1;          // mode that goes with sub1
    logic [3:0]         sub1;
    vram_word_u         word1;          // fetched word, two views
    logic [3:0]         pix4;           // grey level in 4bpp
    logic               pix1;           // bit in 1bpp
    logic [11:0]        rgb1;           // colour before output flop

    assign h_last = (h_cnt == HW'(H_TOT - 1));
    assign v_last = (v_cnt == VW'(V_TOT - 1));

    // raster counters, visible then fp, sync, bp
    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            h_cnt <= h_last ? '0 : h_cnt + 1'b1;
            if (h_last) begin
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end
        end
    end

    assign vis0 = (h_cnt < HW'(H_VIS)) && (v_cnt < VW'(V_VIS));
    assign hs0  = !((h_cnt >= HW'(H_VIS + H_FP)) && (h_cnt < HW'(H_VIS + H_FP + H_SYNC)));
    assign vs0  = !((v_cnt >= VW'(V_VIS + V_FP)) && (v_cnt < VW'(V_VIS + V_FP + V_SYNC)));

    assign sub_last = cfg_i.mode_1bpp ? (sub_cnt == 4'd15) : (sub_cnt[1:0] == 2'd3);

    // word address runs on across lines, reloaded just before pixel 0,0
    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            fetch_addr <= '0;
            sub_cnt    <= '0;
        end else if (h_last && v_last) begin
            fetch_addr <= cfg_i.start[VRAM_AW-1:0];
            sub_cnt    <= '0;
        end else if (vis0) begin
            sub_cnt <= sub_last ? 4'd0 : sub_cnt + 4'd1;
            if (sub_last) begin
                fetch_addr <= fetch_addr + 1'b1;   // wraps at top of memory
            end
        end
    end

    assign fetch_addr_o = fetch_addr;

    // stage 1 control, lines up with the returning word
    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            vis1 <= 1'b0;
            hs1  <= 1'b1;
            vs1  <= 1'b1;
        end else begin
            vis1 <= vis0;
            hs1  <= hs0;
            vs1  <= vs0;
        end
    end

    always_ff @(posedge pclk) begin
        sub1  <= sub_cnt;
        mode1 <= cfg_i.mode_1bpp;
    end

    // leftmost pixel sits in the top bits, so invert the index
    assign word1 = fetch_data_i;
    assign pix4  = word1.pix4[~sub1[1:0]];
    assign pix1  = word1.pix1[~sub1];

    always_comb begin
        if (!vis1) begin
            rgb1 = 12'h000;                         // blank outside display
        end else if (mode1) begin
            rgb1 = pix1 ? cfg_i.fg : cfg_i.bg;
        end else begin
            rgb1 = {pix4, pix4, pix4};              // grey
        end
    end

    // stage 2, all outputs registered together
    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            de_o    <= 1'b0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
            red_o   <= 4'h0;
            green_o <= 4'h0;
            blue_o  <= 4'h0;
        end else begin
            de_o    <= vis1;
            hsync_o <= hs1;
            vsync_o <= vs1;
            {red_o, green_o, blue_o} <= rgb1;
        end
    end

endmodule

`default_nettype wire

// File: design/xosera_vram.sv
`default_nettype none
`timescale 1ns/1ps

module xosera_vram #(
    parameter int VRAM_AW = 8           // words = 2**VRAM_AW
) (
    input  logic               pclk,
    input  logic [VRAM_AW-1:0] a_addr_i,    // bus port address
    input  logic               a_we_i,      // bus port write strobe
    input  logic [15:0]        a_wdata_i,   // bus port write word
    output logic [15:0]        a_rdata_o,   // bus port read, 1 cycle
    input  logic [VRAM_AW-1:0] b_addr_i,    // raster port address
    output logic [15:0]        b_rdata_o    // raster port read, 1 cycle
);

    logic [15:0] mem [2**VRAM_AW];      // inferred block ram

    // port a, read returns the old word on a write cycle
    always_ff @(posedge pclk) begin
        if (a_we_i) begin
            mem[a_addr_i] <= a_wdata_i;
        end
        a_rdata_o <= mem[a_addr_i];
    end

    // port b, raster fetch only
    always_ff @(posedge pclk) begin
        b_rdata_o <= mem[b_addr_i];
    end

endmodule

`default_nettype wire

// File: design/xosera_reg_exec.sv
`default_nettype none
`timescale 1ns/1ps

module xosera_reg_exec #(
    parameter int VRAM_AW = 8           // video memory address bits
) (
    input  logic                          pclk,
    input  logic                          rst_n_i,
    input  xosera_bus_pkg::bus_access_t   access_i,     // record from decode
    output logic [VRAM_AW-1:0]            vram_addr_o,  // bus port address
    output logic                          vram_we_o,    // bus port write strobe
    output logic [15:0]                   vram_wdata_o, // bus port write word
    input  logic [15:0]                   vram_rdata_i, // word at vram_addr_o
    output xosera_video_pkg::disp_cfg_t   cfg_o,        // display settings
    output logic [7:0]                    bus_data_o    // read byte to host
);
    import xosera_bus_pkg::*;

    logic [7:0]         hi_latch;       // even byte waiting for its odd half
    logic [VRAM_AW-1:0] vram_addr;      // current video memory address
    logic [15:0]        addr_incr;      // auto-increment step
    logic [15:0]        disp_mode;      // bit 0 is 1bpp select
    logic [15:0]        disp_start;     // frame start word
    logic [15:0]        fg_color;       // low 12 bits used
    logic [15:0]        bg_color;       // low 12 bits used
    logic               wr_odd;         // odd byte write, completes a word
    logic [15:0]        wr_word;        // latched high byte plus new low byte
    logic [15:0]        rd_word;        // register value for read-back

    assign wr_odd  = access_i.valid && access_i.write && access_i.bytesel;
    assign wr_word = {hi_latch, access_i.data};

    // memory write lands on the same edge as the register update
    assign vram_addr_o  = vram_addr;
    assign vram_we_o    = wr_odd && (access_i.reg_num == VRAM_DATA);
    assign vram_wdata_o = wr_word;

    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            hi_latch   <= 8'h00;
            vram_addr  <= '0;
            addr_incr  <= 16'h0001;     // sequential access by default
            disp_mode  <= 16'h0000;
            disp_start <= 16'h0000;
            fg_color   <= 16'h0000;
            bg_color   <= 16'h0000;
        end else if (access_i.valid && access_i.write) begin
            if (!access_i.bytesel) begin
                hi_latch <= access_i.data;  // even byte only latches
            end else begin
                case (access_i.reg_num)
                    VRAM_ADDR:  vram_addr  <= wr_word[VRAM_AW-1:0];
                    VRAM_DATA:  vram_addr  <= vram_addr + addr_incr[VRAM_AW-1:0]; // wraps
                    ADDR_INCR:  addr_incr  <= wr_word;
                    DISP_MODE:  disp_mode  <= wr_word;
                    DISP_START: disp_start <= wr_word;
                    FG_COLOR:   fg_color   <= wr_word;
                    BG_COLOR:   bg_color   <= wr_word;
                    default:    ;           // unused numbers ignore writes
                endcase
            end
        end
    end

    // read-back word select
    always_comb begin
        case (access_i.reg_num)
            VRAM_ADDR:  rd_word = 16'(vram_addr);   // zero extended
            VRAM_DATA:  rd_word = vram_rdata_i;
            ADDR_INCR:  rd_word = addr_incr;
            DISP_MODE:  rd_word = disp_mode;
            DISP_START: rd_word = disp_start;
            FG_COLOR:   rd_word = fg_color;
            BG_COLOR:   rd_word = bg_color;
            default:    rd_word = 16'h0000;
        endcase
    end

    // host samples this until select rises, so just hold between reads
    always_ff @(posedge pclk) begin
        if (access_i.valid && !access_i.write) begin
            bus_data_o <= access_i.bytesel ? rd_word[7:0] : rd_word[15:8];
        end
    end

    assign cfg_o.mode_1bpp = disp_mode[0];
    assign cfg_o.start     = disp_start;
    assign cfg_o.fg        = fg_color[11:0];
    assign cfg_o.bg        = bg_color[11:0];

endmodule

`default_nettype wire

// File: design/xosera_bus_decode.sv
`default_nettype none
`timescale 1ns/1ps

module xosera_bus_decode (
    input  logic                        pclk,
    input  logic                        rst_n_i,
    input  logic                        bus_sel_n_i,    // host select, active low
    input  logic                        bus_rd_nwr_i,   // 1 read, 0 write
    input  logic                        bus_bytesel_i,  // 0 even byte, 1 odd byte
    input  logic [3:0]                  bus_reg_num_i,  // register number
    input  logic [7:0]                  bus_data_i,     // write data from host
    output xosera_bus_pkg::bus_access_t access_o        // one record per access
);
    import xosera_bus_pkg::*;

    bus_access_t pin_meta;              // first flop, valid holds select active
    bus_access_t pin_sync;              // second flop, safe to use
    logic        sel_prev;              // synced select one cycle back
    logic        sel_fall;              // select just went active
    bus_access_t acc_q;                 // registered record

    // all pins ride the same two flops so they stay aligned with select
    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            pin_meta.valid <= 1'b0;     // idle bus
            pin_sync.valid <= 1'b0;
            sel_prev       <= 1'b0;
        end else begin
            pin_meta.valid   <= !bus_sel_n_i;
            pin_meta.write   <= !bus_rd_nwr_i;
            pin_meta.bytesel <= bus_bytesel_i;
            pin_meta.reg_num <= reg_num_e'(bus_reg_num_i);
            pin_meta.data    <= bus_data_i;
            pin_sync         <= pin_meta;
            sel_prev         <= pin_sync.valid;
        end
    end

    assign sel_fall = pin_sync.valid && !sel_prev;  // leading edge of select

    // pins are stable while select is low, so capture them on the edge
    always_ff @(posedge pclk) begin
        if (!rst_n_i) begin
            acc_q.valid <= 1'b0;
        end else begin
            acc_q.valid   <= sel_fall;
            acc_q.write   <= pin_sync.write;
            acc_q.bytesel <= pin_sync.bytesel;
            acc_q.reg_num <= pin_sync.reg_num;
            if (pin_sync.write) begin
                acc_q.data <= pin_sync.data;
            end else begin
                acc_q.data <= 8'h00;    // reads carry no data
            end
        end
    end

    assign access_o = acc_q;

endmodule

`default_nettype wire

// File: design/xosera_video_pkg.sv
`default_nettype none

// display side definitions shared by execute, video and testbench
package xosera_video_pkg;

    // display configuration, driven from the register file
    typedef struct packed {
        logic        mode_1bpp;         // 0 four grey pixels, 1 sixteen mono pixels
        logic [15:0] start;             // word address of top-left pixel
        logic [11:0] fg;                // rgb 4:4:4 for set bits
        logic [11:0] bg;                // rgb 4:4:4 for clear bits
    } disp_cfg_t;

    // one video memory word, seen either way depending on mode
    typedef union packed {
        logic [3:0][3:0] pix4;          // pix4[3] is leftmost pixel
        logic [15:0]     pix1;          // bit 15 is leftmost pixel
    } vram_word_u;

endpackage

`default_nettype wire

// File: design/xosera_bus_pkg.sv
`default_nettype none

// host register port definitions shared by decode, execute and testbench
package xosera_bus_pkg;

    // register numbers on the 4-bit reg_num pins
    typedef enum logic [3:0] {
        VRAM_ADDR  = 4'h0,              // video memory address
        VRAM_DATA  = 4'h1,              // memory word at address, auto-increments on write
        ADDR_INCR  = 4'h2,              // added to address after each data write
        DISP_MODE  = 4'h3,              // bit 0 selects 1 bit per pixel
        DISP_START = 4'h4,              // first word shown at top of frame
        FG_COLOR   = 4'h5,              // 12-bit rgb for set bits
        BG_COLOR   = 4'h6               // 12-bit rgb for clear bits
    } reg_num_e;                        // codes 7..15 are unused and read zero

    // one completed host access, as seen after synchronization
    typedef struct packed {
        logic       valid;              // high one cycle per select fall
        logic       write;              // 1 write, 0 read
        logic       bytesel;            // 0 even (high) byte, 1 odd (low) byte
        reg_num_e   reg_num;            // register addressed
        logic [7:0] data;               // write byte, zero on reads
    } bus_access_t;

endpackage

`default_nettype wire
